/* design/lsu_pkg.sv */
/*
 * LSU shared definitions
 * Access sizes, memory map regions, exception types, the control
 * packet, the per-stage payload and the DC3 error report, plus the
 * default DCCM and PIC region bounds.
 */
`default_nettype none

package lsu_pkg;

   //****************************************
   // Encodings
   //****************************************

   typedef enum logic [1:0] {
      SZ_BYTE = 2'b00,
      SZ_HALF = 2'b01,
      SZ_WORD = 2'b10
   } lsu_size_e;

   typedef enum logic [1:0] {
      REG_DCCM     = 2'b00,
      REG_PIC      = 2'b01,
      REG_EXTERNAL = 2'b10
   } lsu_region_e;

   // Misaligned reports as 0, any other access fault as 1
   typedef enum logic {
      EXC_ACCESS     = 1'b1,
      EXC_MISALIGNED = 1'b0
   } lsu_exc_e;

   //****************************************
   // Packets
   //****************************************

   typedef struct packed {
      logic      valid;
      logic      dma;
      logic      load;
      logic      store;
      logic      unsign;
      lsu_size_e size;
   } lsu_pkt_t;

   // Everything one DC stage carries down the pipe
   typedef struct packed {
      lsu_pkt_t    pkt;
      logic [31:0] addr;
      logic [31:0] end_addr;
      logic [31:0] store_data;
      lsu_region_e region;
      logic        access_fault;
      logic        misaligned_fault;
   } lsu_stage_t;

   typedef struct packed {
      logic        exc_valid;
      logic        dma_valid;
      logic        is_store;
      lsu_exc_e    exc_type;
      logic [31:0] addr;
   } lsu_error_pkt_t;

   //****************************************
   // Default memory map
   //****************************************

   localparam logic [31:0] LSU_DCCM_BASE = 32'hF004_0000;
   localparam logic [31:0] LSU_DCCM_SIZE = 32'h0001_0000;  // 64 KiB
   localparam logic [31:0] LSU_PIC_BASE  = 32'hF00C_0000;
   localparam logic [31:0] LSU_PIC_SIZE  = 32'h0000_8000;  // 32 KiB

endpackage

`default_nettype wire

/* design/lsu_addr_gen.sv */
/*
 * LSU DC1 address generation
 * Muxes the DMA and core requests into DC1, forms the start and end
 * addresses, classifies them against the memory map and flags access
 * and misalignment faults. DMA write data is lane shifted here.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_addr_gen
   import lsu_pkg::*;
#(
   parameter logic [31:0] DCCM_BASE = LSU_DCCM_BASE,
   parameter logic [31:0] DCCM_SIZE = LSU_DCCM_SIZE,
   parameter logic [31:0] PIC_BASE  = LSU_PIC_BASE,
   parameter logic [31:0] PIC_SIZE  = LSU_PIC_SIZE
) (
   input  logic        clk,
   input  logic        rst_n,
   input  lsu_pkt_t    lsu_p,
   input  logic [31:0] rs1,
   input  logic [11:0] offset,
   input  logic [31:0] rs2,
   input  logic        dma_req,
   input  logic        dma_write,
   input  logic [31:0] dma_addr,
   input  lsu_size_e   dma_size,
   input  logic [31:0] dma_wdata,
   input  logic        flush_dc2_up,
   output lsu_stage_t  dc1
);

   lsu_pkt_t    dma_pkt;
   lsu_pkt_t    pkt_d;
   logic [31:0] base_d;
   logic [11:0] offset_d;
   logic [31:0] store_data_d;

   logic        valid_dc1;
   lsu_pkt_t    pkt_dc1;
   logic [31:0] base_dc1;
   logic [11:0] offset_dc1;
   logic [31:0] store_data_dc1;

   logic [31:0] addr_dc1;
   logic [31:0] end_addr_dc1;
   logic [1:0]  size_m1;
   logic        unaligned;
   lsu_region_e start_region;
   lsu_region_e end_region;

   function automatic lsu_region_e region_of(input logic [31:0] a);
      if ((a >= DCCM_BASE) && ((a - DCCM_BASE) < DCCM_SIZE)) begin
         return REG_DCCM;
      end
      if ((a >= PIC_BASE) && ((a - PIC_BASE) < PIC_SIZE)) begin
         return REG_PIC;
      end
      return REG_EXTERNAL;
   endfunction

   //****************************************
   // Request select
   //****************************************

   always_comb begin
      dma_pkt.valid  = dma_req;
      dma_pkt.dma    = 1'b1;
      dma_pkt.load   = ~dma_write;
      dma_pkt.store  = dma_write;
      dma_pkt.unsign = 1'b0;
      dma_pkt.size   = dma_size;

      pkt_d = dma_req ? dma_pkt : lsu_p;
      // A flushed core request never reaches DC1
      pkt_d.valid = (lsu_p.valid & ~flush_dc2_up) | dma_req;
   end

   assign base_d   = dma_req ? dma_addr : rs1;
   assign offset_d = dma_req ? 12'h000 : offset;

   // DMA data arrives on its byte lane, stores expect it at bit 0
   assign store_data_d = dma_req ? (dma_wdata >> {dma_addr[1:0], 3'b000}) : rs2;

   //****************************************
   // DC1 registers
   //****************************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_dc1 <= 1'b0;
      end else begin
         valid_dc1 <= pkt_d.valid;
      end
   end

   always_ff @(posedge clk) begin
      pkt_dc1        <= pkt_d;
      base_dc1       <= base_d;
      offset_dc1     <= offset_d;
      store_data_dc1 <= store_data_d;
   end

   //****************************************
   // Address and checks
   //****************************************

   always_comb begin
      case (pkt_dc1.size)
         SZ_BYTE: size_m1 = 2'd0;
         SZ_HALF: size_m1 = 2'd1;
         default: size_m1 = 2'd3;
      endcase
   end

   assign addr_dc1     = base_dc1 + {{20{offset_dc1[11]}}, offset_dc1};
   assign end_addr_dc1 = addr_dc1 + {30'b0, size_m1};

   assign start_region = region_of(addr_dc1);
   assign end_region   = region_of(end_addr_dc1);

   always_comb begin
      case (pkt_dc1.size)
         SZ_HALF: unaligned = addr_dc1[0];
         SZ_WORD: unaligned = |addr_dc1[1:0];
         default: unaligned = 1'b0;
      endcase
   end

   always_comb begin
      dc1.pkt        = pkt_dc1;
      dc1.pkt.valid  = valid_dc1;
      dc1.addr       = addr_dc1;
      dc1.end_addr   = end_addr_dc1;
      dc1.store_data = store_data_dc1;
      dc1.region     = start_region;
      // Crossing a region boundary, or a PIC access narrower than a word
      dc1.access_fault = (start_region != end_region) |
                         ((start_region == REG_PIC) & (pkt_dc1.size != SZ_WORD));
      // DCCM handles unaligned accesses itself
      dc1.misaligned_fault = unaligned & (start_region != REG_DCCM);
   end

endmodule

`default_nettype wire

/* design/lsu_pipe_stage.sv */
/*
 * LSU pipeline stage register
 * Moves one stage payload forward each cycle. A flush removes core
 * entries while DMA entries always pass.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_pipe_stage
   import lsu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       flush,
   input  lsu_stage_t d,
   output lsu_stage_t q
);

   logic       valid_q;
   lsu_stage_t data_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= d.pkt.valid & ~(flush & ~d.pkt.dma);
      end
   end

   // Payload follows blindly, only valid qualifies it
   always_ff @(posedge clk) begin
      data_q <= d;
   end

   always_comb begin
      q           = data_q;
      q.pkt.valid = valid_q;
   end

endmodule

`default_nettype wire

/* design/lsu_retire.sv */
/*
 * LSU retire logic
 * Selects and extends load data at DC3, reports faults and bus errors
 * in the DC3 error packet, and raises the DC5 commit.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_retire
   import lsu_pkg::*;
(
   input  lsu_stage_t     dc3,
   input  lsu_stage_t     dc5,
   input  logic [31:0]    dccm_rdata_dc3,
   input  logic [31:0]    bus_rdata_dc3,
   input  logic           bus_error_dc3,
   input  logic           flush_dc3,
   input  logic           flush_dc5,
   output logic [31:0]    lsu_result_dc3,
   output lsu_error_pkt_t lsu_error_pkt_dc3,
   output logic           lsu_commit_dc5
);

   logic [31:0] ld_data_dc3;
   logic        fault_dc3;
   logic        core_valid_dc3;

   //****************************************
   // Load result
   //****************************************

   assign ld_data_dc3 = (dc3.region == REG_EXTERNAL) ? bus_rdata_dc3 : dccm_rdata_dc3;

   always_comb begin
      case (dc3.pkt.size)
         SZ_BYTE: begin
            if (dc3.pkt.unsign) begin
               lsu_result_dc3 = {24'b0, ld_data_dc3[7:0]};
            end else begin
               lsu_result_dc3 = {{24{ld_data_dc3[7]}}, ld_data_dc3[7:0]};
            end
         end
         SZ_HALF: begin
            if (dc3.pkt.unsign) begin
               lsu_result_dc3 = {16'b0, ld_data_dc3[15:0]};
            end else begin
               lsu_result_dc3 = {{16{ld_data_dc3[15]}}, ld_data_dc3[15:0]};
            end
         end
         default: lsu_result_dc3 = ld_data_dc3;
      endcase
   end

   //****************************************
   // DC3 error packet
   //****************************************

   assign fault_dc3      = dc3.access_fault | dc3.misaligned_fault | bus_error_dc3;
   assign core_valid_dc3 = dc3.pkt.valid & ~dc3.pkt.dma;

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = fault_dc3 & core_valid_dc3 & ~flush_dc3;
      lsu_error_pkt_dc3.dma_valid = dc3.pkt.dma;
      lsu_error_pkt_dc3.is_store  = dc3.pkt.store;
      // Misalignment takes priority in the reported cause
      lsu_error_pkt_dc3.exc_type  = dc3.misaligned_fault ? EXC_MISALIGNED : EXC_ACCESS;
      lsu_error_pkt_dc3.addr      = dc3.addr;
   end

   //****************************************
   // DC5 commit
   //****************************************

   assign lsu_commit_dc5 = dc5.pkt.valid & ~dc5.pkt.dma &
                           (dc5.pkt.load | dc5.pkt.store) & ~flush_dc5;

endmodule

`default_nettype wire

/* design/lsu_ctl_top.sv */
/*
 * LSU control path top
 * DC1 address generation, the DC2 to DC5 stage registers and the
 * DC3/DC5 retire logic. The DC5 payload goes out to the store path.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_ctl_top
   import lsu_pkg::*;
#(
   parameter int          PIPE_DEPTH = 4,
   parameter logic [31:0] DCCM_BASE  = LSU_DCCM_BASE,
   parameter logic [31:0] DCCM_SIZE  = LSU_DCCM_SIZE,
   parameter logic [31:0] PIC_BASE   = LSU_PIC_BASE,
   parameter logic [31:0] PIC_SIZE   = LSU_PIC_SIZE
) (
   input  logic           clk,
   input  logic           rst_n,
   input  lsu_pkt_t       lsu_p,
   input  logic [31:0]    rs1,
   input  logic [11:0]    offset,
   input  logic [31:0]    rs2,
   input  logic           dma_req,
   input  logic           dma_write,
   input  logic [31:0]    dma_addr,
   input  lsu_size_e      dma_size,
   input  logic [31:0]    dma_wdata,
   input  logic           flush_dc2_up,
   input  logic           flush_dc3,
   input  logic           flush_dc4,
   input  logic           flush_dc5,
   input  logic [31:0]    dccm_rdata_dc3,
   input  logic [31:0]    bus_rdata_dc3,
   input  logic           bus_error_dc3,
   output logic [31:0]    lsu_result_dc3,
   output lsu_error_pkt_t lsu_error_pkt_dc3,
   output logic           lsu_commit_dc5,
   output lsu_stage_t     lsu_dc5
);

   // pipe[0] is DC1, pipe[k+1] is the output of stage k
   lsu_stage_t            pipe [PIPE_DEPTH+1];
   logic [PIPE_DEPTH-1:0] stage_flush;

   assign stage_flush[0] = flush_dc2_up;
   assign stage_flush[1] = flush_dc2_up;
   assign stage_flush[2] = flush_dc3;
   assign stage_flush[3] = flush_dc4;

   lsu_addr_gen #(
      .DCCM_BASE (DCCM_BASE),
      .DCCM_SIZE (DCCM_SIZE),
      .PIC_BASE  (PIC_BASE),
      .PIC_SIZE  (PIC_SIZE)
   ) lsu_addr_gen_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .lsu_p        (lsu_p),
      .rs1          (rs1),
      .offset       (offset),
      .rs2          (rs2),
      .dma_req      (dma_req),
      .dma_write    (dma_write),
      .dma_addr     (dma_addr),
      .dma_size     (dma_size),
      .dma_wdata    (dma_wdata),
      .flush_dc2_up (flush_dc2_up),
      .dc1          (pipe[0])
   );

   genvar k;
   generate
      // Stages past DC5 only delay the entry
      for (k = 4; k < PIPE_DEPTH; k++) begin : g_extra_flush
         assign stage_flush[k] = 1'b0;
      end

      for (k = 0; k < PIPE_DEPTH; k++) begin : g_stage
         lsu_pipe_stage lsu_pipe_stage_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .flush (stage_flush[k]),
            .d     (pipe[k]),
            .q     (pipe[k+1])
         );
      end
   endgenerate

   lsu_retire lsu_retire_inst (
      .dc3               (pipe[2]),
      .dc5               (pipe[4]),
      .dccm_rdata_dc3    (dccm_rdata_dc3),
      .bus_rdata_dc3     (bus_rdata_dc3),
      .bus_error_dc3     (bus_error_dc3),
      .flush_dc3         (flush_dc3),
      .flush_dc5         (flush_dc5),
      .lsu_result_dc3    (lsu_result_dc3),
      .lsu_error_pkt_dc3 (lsu_error_pkt_dc3),
      .lsu_commit_dc5    (lsu_commit_dc5)
   );

   assign lsu_dc5 = pipe[4];

endmodule

`default_nettype wire

/* testbench/lsu_ctl_tests.svh */
/*
 * LSU control path directed tests
 * Address generation, load extension, faults, DMA lane shift and
 * flush behavior, each driven through the top level and checked.
 */

function automatic lsu_pkt_t make_pkt(input logic load, input lsu_size_e sz,
                                      input logic unsign);
   lsu_pkt_t p;
   p.valid  = 1'b1;
   p.dma    = 1'b0;
   p.load   = load;
   p.store  = ~load;
   p.unsign = unsign;
   p.size   = sz;
   return p;
endfunction

// One core request followed from issue to one cycle past DC5
task automatic run_core(input string name, input lsu_pkt_t p, input logic [31:0] base,
                        input logic [11:0] off, input logic [31:0] data,
                        input logic [31:0] dccm_data, input logic [31:0] bus_data,
                        input logic bus_err);
   logic [31:0] a;
   logic        mis;
   logic        exc;
   lsu_exc_e    exp_type;
   a        = model_addr(base, off);
   mis      = model_misaligned(a, p.size);
   exc      = model_access_fault(a, p.size) | mis | bus_err;
   exp_type = mis ? EXC_MISALIGNED : EXC_ACCESS;
   @(posedge clk);
   lsu_p  <= p;
   rs1    <= base;
   offset <= off;
   rs2    <= data;
   @(posedge clk);
   lsu_p <= '0;
   repeat (2) @(posedge clk);
   // Entry now sits in DC3
   dccm_rdata_dc3 <= dccm_data;
   bus_rdata_dc3  <= bus_data;
   bus_error_dc3  <= bus_err;
   @(negedge clk);
   if (p.load && !exc) begin
      check_value({name, " result"}, model_extend((model_region(a) == REG_EXTERNAL) ?
                  bus_data : dccm_data, p.size, p.unsign), lsu_result_dc3);
   end
   check_value({name, " exc_valid"}, 32'(exc), 32'(lsu_error_pkt_dc3.exc_valid));
   check_value({name, " dma_valid"}, 32'd0, 32'(lsu_error_pkt_dc3.dma_valid));
   if (exc) begin
      check_value({name, " exc_type"}, 32'(exp_type), 32'(lsu_error_pkt_dc3.exc_type));
      check_value({name, " exc addr"}, a, lsu_error_pkt_dc3.addr);
      check_value({name, " is_store"}, 32'(p.store), 32'(lsu_error_pkt_dc3.is_store));
   end
   @(posedge clk);
   bus_error_dc3 <= 1'b0;
   // The core takes the trap and flushes the entry out of DC4
   flush_dc4 <= exc;
   @(negedge clk);
   check_value({name, " early commit"}, 32'd0, 32'(lsu_commit_dc5));
   @(posedge clk);
   flush_dc4 <= 1'b0;
   @(negedge clk);
   check_value({name, " commit"}, 32'(!exc), 32'(lsu_commit_dc5));
   check_value({name, " dc5 addr"}, a, lsu_dc5.addr);
   check_value({name, " dc5 end_addr"}, a + size_bytes(p.size) - 32'd1, lsu_dc5.end_addr);
   check_value({name, " dc5 region"}, 32'(model_region(a)), 32'(lsu_dc5.region));
   if (p.store) begin
      check_value({name, " dc5 store_data"}, data, lsu_dc5.store_data);
   end
   @(posedge clk);
   @(negedge clk);
   check_value({name, " late commit"}, 32'd0, 32'(lsu_commit_dc5));
endtask

task automatic test_addr_gen();
   logic [31:0] a;
   logic [11:0] off;
   for (int i = 0; i < 4; i++) begin
      a   = LSU_DCCM_BASE + 32'h1000 + ($random(seed) & 32'h0000_CFFC);
      off = 12'($random(seed)) & 12'hFFC;
      run_core("addr_gen", make_pkt(1'b1, SZ_WORD, 1'b0), a - 32'($signed(off)), off,
               $random(seed), $random(seed), $random(seed), 1'b0);
   end
endtask

task automatic test_load_extend();
   lsu_size_e sizes [3] = '{SZ_BYTE, SZ_HALF, SZ_WORD};
   logic [31:0] a;
   for (int s = 0; s < 3; s++) begin
      for (int u = 0; u < 2; u++) begin
         a = LSU_DCCM_BASE + ($random(seed) & 32'h0000_FFF0);
         run_core($sformatf("load_extend size %0d unsign %0d", s, u),
                  make_pkt(1'b1, sizes[s], u[0]), a, 12'h004, 32'h0, $random(seed),
                  $random(seed), 1'b0);
      end
   end
   // External loads take the bus data
   run_core("load_extend external", make_pkt(1'b1, SZ_BYTE, 1'b0),
            32'h4000_0000 + ($random(seed) & 32'h0000_FFFC), 12'h000, 32'h0,
            32'h0000_0011, 32'h0000_00A5, 1'b0);
endtask

task automatic test_faults();
   run_core("fault misaligned", make_pkt(1'b0, SZ_HALF, 1'b0), 32'h2000_0100, 12'h001,
            $random(seed), 32'h0, 32'h0, 1'b0);
   run_core("fault pic byte", make_pkt(1'b1, SZ_BYTE, 1'b1), LSU_PIC_BASE + 32'h20,
            12'h001, 32'h0, 32'h0, 32'h0, 1'b0);
   run_core("fault dccm top", make_pkt(1'b1, SZ_WORD, 1'b0),
            LSU_DCCM_BASE + LSU_DCCM_SIZE - 32'h10, 12'h00E, 32'h0, 32'h0, 32'h0, 1'b0);
   run_core("fault bus error", make_pkt(1'b1, SZ_WORD, 1'b0), LSU_DCCM_BASE + 32'h100,
            12'h000, 32'h0, 32'h0, 32'h0, 1'b1);
endtask

task automatic test_dma();
   lsu_size_e   sizes [3] = '{SZ_BYTE, SZ_HALF, SZ_WORD};
   logic [31:0] a;
   logic [31:0] wdata;
   int          lane;
   string       name;
   for (int s = 0; s < 3; s++) begin
      lane  = (s == 0) ? ($random(seed) & 3) : ((s == 1) ? ($random(seed) & 2) : 0);
      a     = LSU_DCCM_BASE + ($random(seed) & 32'h0000_FFF0) + 32'(lane);
      wdata = $random(seed);
      name  = $sformatf("dma size %0d lane %0d", s, lane);
      @(posedge clk);
      dma_req   <= 1'b1;
      dma_write <= 1'b1;
      dma_addr  <= a;
      dma_size  <= sizes[s];
      dma_wdata <= wdata;
      @(posedge clk);
      dma_req   <= 1'b0;
      dma_write <= 1'b0;
      repeat (2) @(posedge clk);
      // A bus error on a DMA entry stays out of the core error report
      bus_error_dc3 <= 1'b1;
      @(negedge clk);
      check_value({name, " exc_valid"}, 32'd0, 32'(lsu_error_pkt_dc3.exc_valid));
      check_value({name, " dma_valid"}, 32'd1, 32'(lsu_error_pkt_dc3.dma_valid));
      @(posedge clk);
      bus_error_dc3 <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_value({name, " commit"}, 32'd0, 32'(lsu_commit_dc5));
      check_value({name, " dc5 valid"}, 32'd1, 32'(lsu_dc5.pkt.valid & lsu_dc5.pkt.dma));
      check_value({name, " dc5 store_data"}, wdata >> (lane * 8), lsu_dc5.store_data);
   end
endtask

// Core A then B back to back, flush_dc3 while B is in DC3
task automatic flush_pair(input string name, input logic b_dma);
   logic [31:0] a_addr;
   logic [31:0] b_addr;
   a_addr = LSU_DCCM_BASE + ($random(seed) & 32'h0000_7FFC);
   b_addr = LSU_DCCM_BASE + 32'h8000 + ($random(seed) & 32'h0000_7FFC);
   @(posedge clk);
   lsu_p  <= make_pkt(1'b1, SZ_WORD, 1'b0);
   rs1    <= a_addr;
   offset <= 12'h000;
   @(posedge clk);
   lsu_p     <= b_dma ? lsu_pkt_t'('0) : make_pkt(1'b1, SZ_WORD, 1'b0);
   rs1       <= b_addr;
   dma_req   <= b_dma;
   dma_addr  <= b_addr;
   dma_size  <= SZ_WORD;
   dma_write <= 1'b0;
   @(posedge clk);
   lsu_p   <= '0;
   dma_req <= 1'b0;
   repeat (2) @(posedge clk);
   flush_dc3 <= 1'b1;
   @(posedge clk);
   flush_dc3 <= 1'b0;
   @(negedge clk);
   check_value({name, " first commit"}, 32'd1, 32'(lsu_commit_dc5));
   check_value({name, " first addr"}, a_addr, lsu_dc5.addr);
   @(posedge clk);
   @(negedge clk);
   check_value({name, " second commit"}, 32'd0, 32'(lsu_commit_dc5));
   check_value({name, " second valid"}, 32'(b_dma), 32'(lsu_dc5.pkt.valid));
   check_value({name, " second addr"}, b_addr, lsu_dc5.addr);
endtask

task automatic test_flush();
   flush_pair("flush core", 1'b0);
   flush_pair("flush dma", 1'b1);
endtask

/* testbench/lsu_ctl_tb.sv */
/*
 * LSU control path testbench
 * Clock, reset and the DUT, the value check, a reference model of the
 * address, region, fault and load extension rules, a cycle limit and
 * the closing report. The directed tests come from the included header.
 */
`timescale 1ns/10ps
`default_nettype none

module lsu_ctl_tb
   import lsu_pkg::*;
();

   // About 20 requests of 8 cycles each, so this leaves a wide margin
   localparam int CYCLE_LIMIT = 2000;

   logic           clk;
   logic           rst_n;
   lsu_pkt_t       lsu_p;
   logic [31:0]    rs1;
   logic [11:0]    offset;
   logic [31:0]    rs2;
   logic           dma_req;
   logic           dma_write;
   logic [31:0]    dma_addr;
   lsu_size_e      dma_size;
   logic [31:0]    dma_wdata;
   logic           flush_dc2_up;
   logic           flush_dc3;
   logic           flush_dc4;
   logic           flush_dc5;
   logic [31:0]    dccm_rdata_dc3;
   logic [31:0]    bus_rdata_dc3;
   logic           bus_error_dc3;
   logic [31:0]    lsu_result_dc3;
   lsu_error_pkt_t lsu_error_pkt_dc3;
   logic           lsu_commit_dc5;
   lsu_stage_t     lsu_dc5;

   integer seed;
   int     error_count;
   int     check_count;
   int     cycle_count = 0;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   lsu_ctl_top #(
      .PIPE_DEPTH (4),
      .DCCM_BASE  (LSU_DCCM_BASE),
      .DCCM_SIZE  (LSU_DCCM_SIZE),
      .PIC_BASE   (LSU_PIC_BASE),
      .PIC_SIZE   (LSU_PIC_SIZE)
   ) lsu_ctl_top_inst (
      .clk               (clk),
      .rst_n             (rst_n),
      .lsu_p             (lsu_p),
      .rs1               (rs1),
      .offset            (offset),
      .rs2               (rs2),
      .dma_req           (dma_req),
      .dma_write         (dma_write),
      .dma_addr          (dma_addr),
      .dma_size          (dma_size),
      .dma_wdata         (dma_wdata),
      .flush_dc2_up      (flush_dc2_up),
      .flush_dc3         (flush_dc3),
      .flush_dc4         (flush_dc4),
      .flush_dc5         (flush_dc5),
      .dccm_rdata_dc3    (dccm_rdata_dc3),
      .bus_rdata_dc3     (bus_rdata_dc3),
      .bus_error_dc3     (bus_error_dc3),
      .lsu_result_dc3    (lsu_result_dc3),
      .lsu_error_pkt_dc3 (lsu_error_pkt_dc3),
      .lsu_commit_dc5    (lsu_commit_dc5),
      .lsu_dc5           (lsu_dc5)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   //****************************************
   // Reference model
   //****************************************

   function automatic lsu_region_e model_region(input logic [31:0] a);
      lsu_region_e r;
      r = REG_EXTERNAL;
      if (a >= LSU_DCCM_BASE && a <= LSU_DCCM_BASE + (LSU_DCCM_SIZE - 32'd1)) begin
         r = REG_DCCM;
      end else if (a >= LSU_PIC_BASE && a <= LSU_PIC_BASE + (LSU_PIC_SIZE - 32'd1)) begin
         r = REG_PIC;
      end
      return r;
   endfunction

   function automatic logic [31:0] size_bytes(input lsu_size_e sz);
      return (sz == SZ_BYTE) ? 32'd1 : ((sz == SZ_HALF) ? 32'd2 : 32'd4);
   endfunction

   function automatic logic [31:0] model_addr(input logic [31:0] base, input logic [11:0] off);
      return base + 32'($signed(off));
   endfunction

   // Region change across the access, or a narrow PIC access
   function automatic logic model_access_fault(input logic [31:0] a, input lsu_size_e sz);
      lsu_region_e r;
      r = model_region(a);
      return (r != model_region(a + size_bytes(sz) - 32'd1)) ||
             (r == REG_PIC && sz != SZ_WORD);
   endfunction

   function automatic logic model_misaligned(input logic [31:0] a, input lsu_size_e sz);
      return ((a % size_bytes(sz)) != 0) && (model_region(a) != REG_DCCM);
   endfunction

   function automatic logic [31:0] model_extend(input logic [31:0] data, input lsu_size_e sz,
                                                input logic unsign);
      logic [31:0] r;
      case (sz)
         SZ_BYTE: r = unsign ? (data & 32'h0000_00FF) : 32'($signed(data[7:0]));
         SZ_HALF: r = unsign ? (data & 32'h0000_FFFF) : 32'($signed(data[15:0]));
         default: r = data;
      endcase
      return r;
   endfunction

   `include "lsu_ctl_tests.svh"

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      seed           = 61;
      error_count    = 0;
      check_count    = 0;
      rst_n          <= 1'b0;
      lsu_p          <= '0;
      rs1            <= '0;
      offset         <= '0;
      rs2            <= '0;
      dma_req        <= 1'b0;
      dma_write      <= 1'b0;
      dma_addr       <= '0;
      dma_size       <= SZ_BYTE;
      dma_wdata      <= '0;
      flush_dc2_up   <= 1'b0;
      flush_dc3      <= 1'b0;
      flush_dc4      <= 1'b0;
      flush_dc5      <= 1'b0;
      dccm_rdata_dc3 <= '0;
      bus_rdata_dc3  <= '0;
      bus_error_dc3  <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("reset commit", 32'd0, 32'(lsu_commit_dc5));
      check_value("reset exc_valid", 32'd0, 32'(lsu_error_pkt_dc3.exc_valid));

      test_addr_gen();
      test_load_extend();
      test_faults();
      test_dma();
      test_flush();

      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
design/lsu_pkg.sv
design/lsu_addr_gen.sv
design/lsu_pipe_stage.sv
design/lsu_retire.sv
design/lsu_ctl_top.sv
testbench/lsu_ctl_tb.sv

/* Makefile */
# Verilator build and run of the LSU control path testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module lsu_ctl_tb -f filelist.f \
		-Mdir obj_dir -o lsu_ctl_sim

# Fails unless the simulation output holds the pass line
run: compile
	@out="$$(./obj_dir/lsu_ctl_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
